/* audio_core.f */
logic/audio_pkg.sv
logic/audio_wb_regs.sv
logic/sample_fifo.sv
logic/i2s_tx.sv
logic/sigma_delta_dac.sv
logic/audio_core.sv
testbench/audio_core_tb.sv

/* testbench/audio_core_tb.sv */
//**************************************************
// testbench of the audio output block
// register table, i2s capture, dac density check
//**************************************************
`timescale 1ns/100ps

module audio_core_tb
    import audio_pkg::*;
();

    localparam logic [31:0] BASE_ADDR  = 32'h9000_0000;
    localparam int          TIMEOUT    = 64;
    localparam int          CAPTURE_N  = 300;
    localparam int          DAC_WINDOW = 4096;
    localparam int          FRAME_CLKS = 256;

    typedef struct packed {
        logic        we;
        logic [31:0] offset;
        logic [31:0] data;
        logic [3:0]  sel;
        logic [31:0] exp_data;
    } bus_op_t;

    logic         clk;
    logic         rst;
    logic [31:0]  wb_adr_i;
    logic [31:0]  wb_dat_i;
    logic [3:0]   wb_sel_i;
    logic         wb_we_i;
    logic         wb_stb_i;
    logic [31:0]  wb_dat_o;
    logic         wb_ack_o;
    logic         i2s_bclk_o;
    logic         i2s_lrclk_o;
    logic         i2s_sdata_o;
    logic         dac_left_o;
    logic         dac_right_o;

    bus_op_t      ops [$];
    sample_pair_t pairs [$];
    logic         cap_lr [CAPTURE_N];
    logic         cap_sd [CAPTURE_N];
    integer       seed;
    int           errors;
    int           checks;

    // depth 4 so that full comes early
    audio_core #(
        .FIFO_DEPTH_BITS(2)
    ) audio_core_i (
        .clk        (clk),
        .rst        (rst),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_sel_i   (wb_sel_i),
        .wb_we_i    (wb_we_i),
        .wb_stb_i   (wb_stb_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .i2s_bclk_o (i2s_bclk_o),
        .i2s_lrclk_o(i2s_lrclk_o),
        .i2s_sdata_o(i2s_sdata_o),
        .dac_left_o (dac_left_o),
        .dac_right_o(dac_right_o)
    );

    always #2 clk = !clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_density(input string name, input int got, input int exp);
        checks++;
        if (got < exp - 1 || got > exp + 1) begin
            errors++;
            $display("[FAIL] %0t %s ones: expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    function automatic void add_op(input logic we, input logic [31:0] offset,
                                   input logic [31:0] data, input logic [3:0] sel,
                                   input logic [31:0] exp_data);
        bus_op_t op;
        op = {we, offset, data, sel, exp_data};
        ops.push_back(op);
    endfunction

    // one strobe cycle, then wait for the ack
    task automatic bus_op(input bus_op_t op, output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        wb_adr_i = BASE_ADDR + op.offset;
        wb_dat_i = op.data;
        wb_sel_i = op.sel;
        wb_we_i  = op.we;
        wb_stb_i = 1'b1;
        @(negedge clk);
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        waited   = 0;
        while (!wb_ack_o) begin
            if (waited == TIMEOUT) abort_run("bus access was never acknowledged");
            @(negedge clk);
            waited++;
        end
        rdata = wb_dat_o;
    endtask

    task automatic write_reg(input logic [31:0] offset, input logic [31:0] data);
        logic [31:0] unused_rdata;
        bus_op({1'b1, offset, data, 4'hf, 32'h0}, unused_rdata);
    endtask

    // bit 31 on the right word commits the pair
    task automatic push_pair(input sample_pair_t p);
        write_reg(REG_AUDIO_LEFT, {8'h00, p.left});
        write_reg(REG_AUDIO_RIGHT, {8'h80, p.right});
    endtask

    function automatic sample_pair_t random_pair();
        logic [31:0]  rnd;
        sample_pair_t p;
        rnd    = $random(seed);
        p.left = rnd[SAMPLE_W-1:0];
        rnd     = $random(seed);
        p.right = rnd[SAMPLE_W-1:0];
        return p;
    endfunction

    task automatic wait_bclk_rise();
        int   waited;
        logic prev;
        waited = 0;
        prev   = i2s_bclk_o;
        @(negedge clk);
        while (!(i2s_bclk_o && !prev)) begin
            if (waited == TIMEOUT) abort_run("i2s bit clock stopped");
            prev = i2s_bclk_o;
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic check_i2s();
        int          r;
        int          base;
        int          lr_match;
        logic [31:0] word;
        logic [31:0] exp_word;
        logic        pad;
        r = -1;
        for (int i = 0; i < CAPTURE_N; i++) begin
            wait_bclk_rise();
            cap_lr[i] = i2s_lrclk_o;
            cap_sd[i] = i2s_sdata_o;
        end
        // first lrclk rise is the right half of the first frame
        for (int i = CAPTURE_N - 1; i > 0; i--) begin
            if (cap_lr[i] && !cap_lr[i-1]) r = i;
        end
        if (r < 32 || r + 224 > CAPTURE_N) begin
            errors++;
            $display("no complete i2s frames found in the capture");
            return;
        end
        for (int k = 0; k < 4; k++) begin
            for (int half = 0; half < 2; half++) begin
                base     = r - 32 + 64 * k + 32 * half;
                word     = '0;
                pad      = 1'b0;
                lr_match = 0;
                for (int j = 0; j < 32; j++) begin
                    if (cap_lr[base + j] == half[0]) lr_match++;
                    // msb one bit clock after the lrclk edge
                    if (j >= 1 && j <= SAMPLE_W) begin
                        word = {word[30:0], cap_sd[base + j]};
                    end else begin
                        pad = pad | cap_sd[base + j];
                    end
                end
                // fourth frame finds the fifo empty
                exp_word = '0;
                if (k < 3) exp_word = half[0] ? {8'h0, pairs[k].right} : {8'h0, pairs[k].left};
                compare("i2s_sdata_o word", word, exp_word);
                compare("i2s_sdata_o padding", {31'b0, pad}, 32'h0);
                compare("i2s_lrclk_o slots", lr_match, 32);
            end
        end
    endtask

    // one frame of the pushed value, then mid scale from the zero pair;
    // the first counted cycle still adds the cleared value
    function automatic int expected_ones(input logic [SAMPLE_W-1:0] s);
        longint offset_val;
        longint total;
        // offset binary is the signed value plus half scale
        offset_val = longint'($signed(s)) + (longint'(1) << (SAMPLE_W - 1));
        total      = FRAME_CLKS * offset_val
                   + (DAC_WINDOW - FRAME_CLKS - 1) * (longint'(1) << (SAMPLE_W - 1));
        return int'(total >> SAMPLE_W);
    endfunction

    task automatic check_dac();
        sample_pair_t p;
        int           waited;
        int           ones_l;
        int           ones_r;
        int           pin_hits;
        write_reg(REG_CTRL0, 32'h0);
        p = random_pair();
        push_pair(p);
        write_reg(REG_CTRL0, 32'h6);
        waited = 0;
        while (!audio_core_i.pop) begin
            if (waited == TIMEOUT) abort_run("no frame strobe in dac mode");
            @(negedge clk);
            waited++;
        end
        ones_l   = 0;
        ones_r   = 0;
        pin_hits = 0;
        repeat (DAC_WINDOW) begin
            @(negedge clk);
            ones_l += int'(dac_left_o);
            ones_r += int'(dac_right_o);
            if (i2s_bclk_o || i2s_lrclk_o || i2s_sdata_o) pin_hits++;
        end
        check_density("dac_left_o", ones_l, expected_ones(p.left));
        check_density("dac_right_o", ones_r, expected_ones(p.right));
        compare("i2s pins high in dac mode", pin_hits, 32'h0);
    endtask

    task automatic build_table();
        // reset values, unmapped offset
        add_op(1'b0, REG_CTRL0, 32'h0, 4'hf, 32'h0);
        add_op(1'b0, REG_STAT0, 32'h0, 4'hf, 32'h2);
        add_op(1'b0, REG_FIFO_LOW, 32'h0, 4'hf, 32'h0);
        add_op(1'b0, REG_FIFO_LEVEL, 32'h0, 4'hf, 32'h0);
        add_op(1'b0, 32'h1c, 32'h0, 4'hf, 32'h0);
        // control bits go through lane 0 only
        add_op(1'b1, REG_CTRL0, 32'ha, 4'h1, 32'h0);
        add_op(1'b0, REG_CTRL0, 32'h0, 4'hf, 32'ha);
        add_op(1'b1, REG_CTRL0, 32'hf, 4'he, 32'h0);
        add_op(1'b0, REG_CTRL0, 32'h0, 4'hf, 32'ha);
        // threshold byte lanes
        add_op(1'b1, REG_FIFO_LOW, 32'h1122_3344, 4'hf, 32'h0);
        add_op(1'b1, REG_FIFO_LOW, 32'haabb_ccdd, 4'h5, 32'h0);
        add_op(1'b0, REG_FIFO_LOW, 32'h0, 4'hf, 32'h11bb_33dd);
        add_op(1'b0, REG_STAT0, 32'h0, 4'hf, 32'h3);
        add_op(1'b1, REG_FIFO_LOW, 32'h2, 4'hf, 32'h0);
        // no push without bit 31 through lane 3
        add_op(1'b1, REG_AUDIO_LEFT, 32'h0012_3456, 4'hf, 32'h0);
        add_op(1'b1, REG_AUDIO_RIGHT, 32'h0065_4321, 4'hf, 32'h0);
        add_op(1'b1, REG_AUDIO_RIGHT, 32'h8065_4321, 4'h7, 32'h0);
        add_op(1'b0, REG_FIFO_LEVEL, 32'h0, 4'hf, 32'h0);
        add_op(1'b1, REG_AUDIO_RIGHT, 32'h8065_4321, 4'hf, 32'h0);
        add_op(1'b0, REG_FIFO_LEVEL, 32'h0, 4'hf, 32'h1);
        add_op(1'b0, REG_STAT0, 32'h0, 4'hf, 32'h1);
        repeat (3) add_op(1'b1, REG_AUDIO_LEFT, 32'h80ab_cdef, 4'hf, 32'h0);
        add_op(1'b0, REG_FIFO_LEVEL, 32'h0, 4'hf, 32'h4);
        add_op(1'b0, REG_STAT0, 32'h0, 4'hf, 32'h4);
        // fifth push is dropped
        add_op(1'b1, REG_AUDIO_LEFT, 32'h8055_5555, 4'hf, 32'h0);
        add_op(1'b0, REG_FIFO_LEVEL, 32'h0, 4'hf, 32'h4);
        // software reset empties the fifo
        add_op(1'b1, REG_CTRL0, 32'h1, 4'h1, 32'h0);
        add_op(1'b0, REG_FIFO_LEVEL, 32'h0, 4'hf, 32'h0);
        add_op(1'b0, REG_STAT0, 32'h0, 4'hf, 32'h3);
        add_op(1'b1, REG_CTRL0, 32'h0, 4'h1, 32'h0);
    endtask

    initial begin
        logic [31:0] rdata;
        clk      = 1'b0;
        rst      = 1'b1;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        wb_we_i  = 1'b0;
        wb_stb_i = 1'b0;
        seed     = 93954;
        errors   = 0;
        checks   = 0;
        build_table();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare("{wb_ack_o, i2s pins, dac pins}",
                {26'b0, wb_ack_o, i2s_bclk_o, i2s_lrclk_o, i2s_sdata_o,
                 dac_left_o, dac_right_o}, 32'h0);
        foreach (ops[i]) begin
            bus_op(ops[i], rdata);
            if (!ops[i].we) compare($sformatf("wb_dat_o at %h", ops[i].offset), rdata,
                                    ops[i].exp_data);
        end
        for (int k = 0; k < 3; k++) begin
            pairs.push_back(random_pair());
            push_pair(pairs[k]);
        end
        write_reg(REG_CTRL0, 32'h8);
        check_i2s();
        check_dac();
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* logic/audio_core.sv */
//**************************************************
// audio output block top level
// regs, sample fifo, i2s transmitter, sigma-delta dac
//**************************************************
`timescale 1ns/100ps

module audio_core
    import audio_pkg::*;
#(
    parameter logic [31:0] BASE_ADDR       = 32'h9000_0000,
    parameter int          FIFO_DEPTH_BITS = 4,
    parameter int          BCLK_DIV        = 2
) (
    input  logic        clk,
    input  logic        rst,

    // wishbone slave
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_we_i,
    input  logic        wb_stb_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,

    // i2s pins
    output logic        i2s_bclk_o,
    output logic        i2s_lrclk_o,
    output logic        i2s_sdata_o,

    // pulse density outputs
    output logic        dac_left_o,
    output logic        dac_right_o
);

    ctrl_t        ctrl;
    sample_pair_t push_sample;
    logic         push;
    fifo_stat_t   fifo_stat;
    sample_pair_t head;
    logic         pop;

    audio_wb_regs #(
        .BASE_ADDR(BASE_ADDR)
    ) regs_i (
        .clk        (clk),
        .rst        (rst),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_sel_i   (wb_sel_i),
        .wb_we_i    (wb_we_i),
        .wb_stb_i   (wb_stb_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .fifo_stat_i(fifo_stat),
        .ctrl_o     (ctrl),
        .sample_o   (push_sample),
        .push_o     (push)
    );

    sample_fifo #(
        .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
    ) fifo_i (
        .clk       (clk),
        .rst       (rst),
        .soft_rst_i(ctrl.soft_rst),
        .push_i    (push),
        .sample_i  (push_sample),
        .pop_i     (pop),
        .head_o    (head),
        .stat_o    (fifo_stat)
    );

    i2s_tx #(
        .BCLK_DIV(BCLK_DIV)
    ) tx_i (
        .clk    (clk),
        .rst    (rst),
        .ctrl_i (ctrl),
        .head_i (head),
        .empty_i(fifo_stat.empty),
        .pop_o  (pop),
        .bclk_o (i2s_bclk_o),
        .lrclk_o(i2s_lrclk_o),
        .sdata_o(i2s_sdata_o)
    );

    // pop doubles as the frame strobe for the dac
    sigma_delta_dac dac_i (
        .clk        (clk),
        .rst        (rst),
        .ctrl_i     (ctrl),
        .load_i     (pop),
        .sample_i   (head),
        .dac_left_o (dac_left_o),
        .dac_right_o(dac_right_o)
    );

endmodule

/* logic/sigma_delta_dac.sv */
//**************************************************
// first order sigma-delta dac, two channels
//**************************************************
`timescale 1ns/100ps

module sigma_delta_dac
    import audio_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  ctrl_t        ctrl_i,
    input  logic         load_i,
    input  sample_pair_t sample_i,
    output logic         dac_left_o,
    output logic         dac_right_o
);

    logic                enable;
    logic [SAMPLE_W-1:0] chan_in [2];
    logic [1:0]          pdm;

    assign enable = ctrl_i.dac_mode && ctrl_i.dac_enable && !ctrl_i.soft_rst;

    // channel 0 left, channel 1 right
    assign chan_in[0] = sample_i.left;
    assign chan_in[1] = sample_i.right;

    for (genvar ch = 0; ch < 2; ch++) begin : g_chan
        logic [SAMPLE_W-1:0] value;
        logic [SAMPLE_W-1:0] acc;
        logic [SAMPLE_W:0]   sum;

        assign sum = {1'b0, acc} + {1'b0, value};

        always_ff @(posedge clk) begin
            if (rst || !enable) begin
                value   <= '0;
                acc     <= '0;
                pdm[ch] <= 1'b0;
            end else begin
                // signed to offset binary
                if (load_i) begin
                    value <= {~chan_in[ch][SAMPLE_W-1], chan_in[ch][SAMPLE_W-2:0]};
                end
                acc     <= sum[SAMPLE_W-1:0];
                // carry out is the pulse density bit
                pdm[ch] <= sum[SAMPLE_W];
            end
        end
    end

    assign dac_left_o  = pdm[0];
    assign dac_right_o = pdm[1];

endmodule

/* logic/i2s_tx.sv */
//**************************************************
// i2s transmitter, bit clock and frame timer
// fifo pop at frame start, 64 bit serializer
//**************************************************
`timescale 1ns/100ps

module i2s_tx
    import audio_pkg::*;
#(
    parameter int BCLK_DIV = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  ctrl_t        ctrl_i,
    input  sample_pair_t head_i,
    input  logic         empty_i,
    output logic         pop_o,
    output logic         bclk_o,
    output logic         lrclk_o,
    output logic         sdata_o
);

    localparam int DIV_W = $clog2(BCLK_DIV + 1);

    logic             i2s_mode;
    logic             active;
    logic [DIV_W-1:0] div_cnt;
    logic             div_tick;
    logic             bclk_q;
    logic             lrclk_q;
    logic             fall;
    logic             frame_start;
    logic [5:0]       slot;
    logic [5:0]       slot_next;
    logic [63:0]      shreg;
    sample_pair_t     frame_pair;

    assign i2s_mode = ctrl_i.i2s_enable && !ctrl_i.dac_mode;

    // the frame timer also paces the DAC
    assign active = !ctrl_i.soft_rst
                 && (i2s_mode || (ctrl_i.dac_enable && ctrl_i.dac_mode));

    assign div_tick    = (div_cnt == DIV_W'(BCLK_DIV - 1));
    assign fall        = div_tick && bclk_q;
    assign slot_next   = slot + 6'd1;
    assign frame_start = fall && (slot == 6'd63);

    // pop and frame strobe in one
    assign pop_o = frame_start;

    assign frame_pair = empty_i ? '0 : head_i;

    // serial pins only move in i2s mode
    assign bclk_o  = i2s_mode && bclk_q;
    assign lrclk_o = i2s_mode && lrclk_q;
    assign sdata_o = i2s_mode && shreg[63];

    always_ff @(posedge clk) begin
        if (rst || !active) begin
            div_cnt <= '0;
            bclk_q  <= 1'b0;
            lrclk_q <= 1'b0;
            slot    <= 6'd63;
            shreg   <= '0;
        end else begin
            if (div_tick) begin
                div_cnt <= '0;
                bclk_q  <= !bclk_q;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            // everything shifts on the falling bit clock edge
            if (fall) begin
                slot    <= slot_next;
                lrclk_q <= slot_next[5];
                if (frame_start) begin
                    // msb one slot after each lrclk edge, then zero fill
                    shreg <= {1'b0, frame_pair.left, 8'b0, frame_pair.right, 7'b0};
                end else begin
                    shreg <= {shreg[62:0], 1'b0};
                end
            end
        end
    end

    a_pop_single: assert property (@(posedge clk) disable iff (rst)
        pop_o |=> !pop_o)
        else $error("pop held for two cycles");

endmodule

/* logic/sample_fifo.sv */
//**************************************************
// synchronous fifo of stereo sample pairs
//**************************************************
`timescale 1ns/100ps

module sample_fifo
    import audio_pkg::*;
#(
    parameter int FIFO_DEPTH_BITS = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         soft_rst_i,
    input  logic         push_i,
    input  sample_pair_t sample_i,
    input  logic         pop_i,
    output sample_pair_t head_o,
    output fifo_stat_t   stat_o
);

    localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;
    localparam logic [FIFO_LEVEL_W-1:0] DEPTH_LVL = FIFO_LEVEL_W'(DEPTH);

    sample_pair_t               mem [DEPTH];
    logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
    logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
    logic [FIFO_LEVEL_W-1:0]    level;
    logic                       do_push;
    logic                       do_pop;

    // full push and empty pop are dropped
    assign do_push = push_i && !stat_o.full;
    assign do_pop  = pop_i && !stat_o.empty;

    assign stat_o.level = level;
    assign stat_o.full  = (level == DEPTH_LVL);
    assign stat_o.empty = (level == '0);

    // zero pair when nothing is queued
    assign head_o = stat_o.empty ? '0 : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || soft_rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the level alone
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= sample_i;
        end
    end

    a_level_bound: assert property (@(posedge clk) disable iff (rst)
        level <= DEPTH_LVL)
        else $error("fifo level above depth");

endmodule

/* logic/audio_wb_regs.sv */
//**************************************************
// wishbone register file of the audio block
// control, threshold, status, level, sample writes
//**************************************************
`timescale 1ns/100ps

module audio_wb_regs
    import audio_pkg::*;
#(
    parameter logic [31:0] BASE_ADDR = 32'h9000_0000
) (
    input  logic         clk,
    input  logic         rst,

    // wishbone slave
    input  logic [31:0]  wb_adr_i,
    input  logic [31:0]  wb_dat_i,
    input  logic [3:0]   wb_sel_i,
    input  logic         wb_we_i,
    input  logic         wb_stb_i,
    output logic [31:0]  wb_dat_o,
    output logic         wb_ack_o,

    // fifo side
    input  fifo_stat_t   fifo_stat_i,
    output ctrl_t        ctrl_o,
    output sample_pair_t sample_o,
    output logic         push_o
);

    logic [31:0] offset;
    logic [31:0] threshold;
    logic [31:0] rd_data;
    logic        fifo_low;
    logic        wr_en;
    logic        wr_left;
    logic        wr_right;
    logic        push_req;

    // decode relative to the base address
    assign offset = wb_adr_i - BASE_ADDR;
    assign wr_en  = wb_stb_i && wb_we_i;

    assign wr_left  = wr_en && (offset == REG_AUDIO_LEFT);
    assign wr_right = wr_en && (offset == REG_AUDIO_RIGHT);

    // bit 31 through lane 3 commits the holding pair
    assign push_req = (wr_left || wr_right) && wb_sel_i[3] && wb_dat_i[31];

    assign fifo_low = {{(32 - FIFO_LEVEL_W){1'b0}}, fifo_stat_i.level} < threshold;

    always_comb begin
        case (offset)
            REG_CTRL0: begin
                rd_data = {28'b0, ctrl_o};
            end
            REG_STAT0: begin
                rd_data = {29'b0, fifo_stat_i.full, fifo_stat_i.empty, fifo_low};
            end
            REG_FIFO_LOW: begin
                rd_data = threshold;
            end
            REG_FIFO_LEVEL: begin
                rd_data = {{(32 - FIFO_LEVEL_W){1'b0}}, fifo_stat_i.level};
            end
            default: begin
                rd_data = 32'h0;
            end
        endcase
    end

    // read data captured in the strobe cycle
    always_ff @(posedge clk) begin
        wb_dat_o <= rd_data;
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_o    <= '0;
            threshold <= '0;
            push_o    <= 1'b0;
            wb_ack_o  <= 1'b0;
        end else begin
            wb_ack_o <= wb_stb_i;
            push_o   <= push_req && !ctrl_o.soft_rst;
            if (wr_en && (offset == REG_CTRL0) && wb_sel_i[0]) begin
                ctrl_o <= ctrl_t'(wb_dat_i[3:0]);
            end
            if (wr_en && (offset == REG_FIFO_LOW)) begin
                for (int i = 0; i < 4; i++) begin
                    if (wb_sel_i[i]) begin
                        threshold[8*i +: 8] <= wb_dat_i[8*i +: 8];
                    end
                end
            end
        end
    end

    // holding pair from bits 23..0 of each word
    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (wr_left && wb_sel_i[i]) begin
                sample_o.left[8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
            if (wr_right && wb_sel_i[i]) begin
                sample_o.right[8*i +: 8] <= wb_dat_i[8*i +: 8];
            end
        end
    end

    // a second ack cycle needs a second strobe cycle behind it
    a_ack_per_strobe: assert property (@(posedge clk) disable iff (rst)
        (wb_ack_o && $past(wb_ack_o)) |-> ($past(wb_stb_i) && $past(wb_stb_i, 2)))
        else $error("wb_ack_o held without a matching strobe");

endmodule

/* logic/audio_pkg.sv */
//**************************************************
// audio output block shared definitions
// register offsets, control/status structs, sample pair
//**************************************************
package audio_pkg;

    // one audio sample word
    localparam int SAMPLE_W = 24;

    // the fifo depth must fit in this level counter width
    localparam int FIFO_LEVEL_W = 8;

    // word offsets from the bus base address
    localparam logic [31:0] REG_CTRL0       = 32'h00;
    localparam logic [31:0] REG_STAT0       = 32'h04;
    localparam logic [31:0] REG_FIFO_LOW    = 32'h08;
    localparam logic [31:0] REG_FIFO_LEVEL  = 32'h0c;
    localparam logic [31:0] REG_AUDIO_LEFT  = 32'h10;
    localparam logic [31:0] REG_AUDIO_RIGHT = 32'h14;

    // stereo sample pair with left in the upper half
    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } sample_pair_t;

    // CTRL0 bits 3..0
    typedef struct packed {
        logic i2s_enable;
        logic dac_enable;
        logic dac_mode;
        logic soft_rst;
    } ctrl_t;

    // fifo state as seen by the register file
    typedef struct packed {
        logic [FIFO_LEVEL_W-1:0] level;
        logic                    full;
        logic                    empty;
    } fifo_stat_t;

endpackage
